// ==== files.f ====
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/register_file.sv
verilog/alu.sv
verilog/immediate_gen.sv
verilog/dataflow.sv
verilog/control_unit.sv
verilog/rv_core.sv
verif/tb_clock.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;

    localparam logic [6:0]  opc_load   = 7'b0000011;
    localparam logic [6:0]  opc_imm    = 7'b0010011;
    localparam logic [6:0]  opc_imm32  = 7'b0011011;
    localparam logic [6:0]  opc_jalr   = 7'b1100111;
    localparam logic [63:0] min_neg    = 64'h8000_0000_0000_0000;
    localparam int          store_base = 'h200;
    localparam int          imem_words = 64;
    localparam int          dmem_words = 128;

    logic        clock;
    logic        reset;
    logic [31:0] instruction;
    logic [63:0] read_data, instruction_address, data_address, write_data;
    logic        data_write;
    logic        halted;

    logic [31:0] imem [imem_words];
    logic [63:0] dmem [dmem_words];
    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];
    string       exp_name [$];
    logic [63:0] op_a, op_b, link, want_addr, want_data;
    logic [31:0] word;
    string       name;
    int          prog_len, cycles, timeout_cycles, idx;
    int          store_errors = 0;
    int          run_errors = 0;

    tb_clock u_clock (.clock(clock));
    rv_core u_dut (.*);
    bind rv_core rv_core_assert u_assert (.*);

    // RV64I encodings
    function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(logic [31:0] word_in);
        imem[prog_len[5:0]] = word_in;
        prog_len++;
    endtask

    // sd rs2 to x5 + offset, with the value the ISA predicts
    task automatic store_result(string test, int rs2, int offset, logic [63:0] value);
        emit(stype(rs2, 5, offset));
        exp_name.push_back(test);
        exp_addr.push_back(64'(store_base + offset));
        exp_data.push_back(value);
    endtask

    assign instruction = imem[instruction_address[7:2]];
    assign read_data   = dmem[data_address[9:3]];

    always @(posedge clock) begin
        if (!reset && data_write) begin
            dmem[data_address[9:3]] <= write_data;
            if (exp_addr.size() == 0) begin
                store_errors++;
                $display("Unexpected store of %h to %h", write_data, data_address);
            end else begin
                name      = exp_name.pop_front();
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                assert (data_address == want_addr) else begin
                    store_errors++;
                    $display("ERROR %s address: expected %h, actual %h",
                             name, want_addr, data_address);
                end
                assert (write_data == want_data) else begin
                    store_errors++;
                    $display("ERROR %s data: expected %h, actual %h",
                             name, want_data, write_data);
                end
            end
        end
    end

    initial begin
        reset    = 1'b1;
        prog_len = 0;
        void'($urandom(32'h9d21));
        op_a = {$urandom(), $urandom()};
        op_b = {$urandom(), $urandom()};
        if (op_b == op_a) begin
            op_b = ~op_a;
        end
        // Unfilled words hold unknown opcodes
        for (idx = 0; idx < imem_words; idx++) begin
            imem[idx[5:0]] = {idx[24:0], 7'b1111111};
        end
        for (idx = 0; idx < dmem_words; idx++) begin
            dmem[idx[6:0]] = {~idx, idx};
        end
        dmem[0] = op_a;
        dmem[1] = op_b;
        dmem[2] = min_neg;
        dmem[3] = 64'd1;

        // x1 = a, x2 = b, x3 = most negative, x4 = 1, x5 = store base
        emit(itype(opc_load, 3, 1, 0, 0));
        emit(itype(opc_load, 3, 2, 0, 8));
        emit(itype(opc_load, 3, 3, 0, 16));
        emit(itype(opc_load, 3, 4, 0, 24));
        emit(itype(opc_imm, 0, 5, 0, store_base));
        emit(rtype(0, 0, 6, 1, 2));
        store_result("add", 6, 0, op_a + op_b);
        emit(rtype(32, 0, 6, 1, 2));
        store_result("sub", 6, 8, op_a - op_b);
        emit(rtype(0, 7, 6, 1, 2));
        store_result("and", 6, 16, op_a & op_b);
        emit(rtype(0, 6, 6, 1, 2));
        store_result("or", 6, 24, op_a | op_b);
        emit(rtype(0, 4, 6, 1, 2));
        store_result("xor", 6, 32, op_a ^ op_b);
        emit(itype(opc_imm, 0, 6, 1, -5));
        store_result("addi", 6, 40, op_a - 64'd5);
        // Low word of x3 minus one sets bit 31
        word = min_neg[31:0] - 32'd1;
        emit(itype(opc_imm32, 0, 6, 3, -1));
        store_result("addiw", 6, 48, {{32{word[31]}}, word});
        emit(itype(opc_imm, 0, 0, 1, 7));
        store_result("x0", 0, 56, 64'd0);
        store_result("round trip", 1, 64, op_a);
        // Each taken branch skips a marker store
        emit(btype(0, 1, 1, 8));
        emit(stype(4, 5, 72));
        emit(btype(0, 1, 2, 8));
        store_result("beq", 4, 80, 64'd1);
        emit(btype(1, 1, 2, 8));
        emit(stype(4, 5, 88));
        emit(btype(1, 1, 1, 8));
        store_result("bne", 4, 96, 64'd1);
        // Both blt cases overflow on rs1 - rs2
        emit(btype(4, 3, 4, 8));
        emit(stype(4, 5, 104));
        emit(btype(4, 4, 3, 8));
        store_result("blt", 4, 112, 64'd1);
        link = 64'(prog_len * 4 + 4);
        emit(jtype(9, 12));
        emit(stype(4, 5, 120));
        emit(stype(4, 5, 128));
        store_result("jal", 9, 136, link);
        // Odd jalr target, bit 0 gets dropped
        emit(itype(opc_imm, 0, 10, 0, prog_len * 4 + 12));
        link = 64'(prog_len * 4 + 4);
        emit(itype(opc_jalr, 0, 11, 10, 1));
        emit(stype(4, 5, 144));
        store_result("jalr", 11, 152, link);
        emit(32'h0000_0000);

        timeout_cycles = 5 * prog_len;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        cycles = 0;
        while (!halted && cycles < timeout_cycles) begin
            @(negedge clock);
            cycles++;
        end
        assert (halted) else begin
            run_errors++;
            $display("Core hung: no halt within %0d cycles", timeout_cycles);
        end
        repeat (3) @(negedge clock);
        assert (exp_addr.size() == 0) else begin
            run_errors++;
            $display("%0d expected stores never happened", exp_addr.size());
        end
        $display("Errors: %0d store, %0d run, %0d assertion",
                 store_errors, run_errors, u_dut.u_assert.fail_count);
        if (store_errors + run_errors + u_dut.u_assert.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verif/rv_core_assert.sv ====
`timescale 1ns/10ps

module rv_core_assert (
    input logic        clock,
    input logic        reset,
    input logic [31:0] instruction,
    input logic [63:0] instruction_address,
    input logic        data_write,
    input logic        halted
);

    int         fail_count = 0;
    logic [6:0] opcode;
    logic       sequential;

    assign opcode     = instruction[6:0];
    // Loads, stores and ALU instructions fall through to the next word
    assign sequential = opcode inside {7'b0000011, 7'b0100011, 7'b0010011, 7'b0011011,
                                       7'b0110011};

    pc_step: assert property (@(posedge clock) disable iff (reset)
        sequential |=> instruction_address == $past(instruction_address) + 64'd4)
    else begin
        fail_count++;
        $error("PC did not advance by 4 after a non-control instruction");
    end

    // Jump targets land on whole words
    pc_aligned: assert property (@(posedge clock) disable iff (reset)
        instruction_address[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("Instruction address is not word aligned");
    end

    store_only: assert property (@(posedge clock) data_write |-> opcode == 7'b0100011)
    else begin
        fail_count++;
        $error("data_write high for an opcode that is not a store");
    end

    // Halt is sticky until reset
    halt_hold: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted && !data_write && $stable(instruction_address))
    else begin
        fail_count++;
        $error("Core left the halted state or kept running after halt");
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clock
);

    // Half of the 100 ns period
    localparam int half_period = 50;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [ilen-1:0] instruction,
    input  logic [xlen-1:0] read_data,
    output logic [xlen-1:0] instruction_address,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data,
    output logic            data_write,
    output logic            halted
);

    // Selects and status between decoder and datapath
    ctrl_if ctrl_bus ();

    control_unit u_control (
        .ctrl       (ctrl_bus.ctrl),
        .data_write (data_write),
        .halted     (halted)
    );

    dataflow u_dataflow (
        .clock               (clock),
        .reset               (reset),
        .instruction         (instruction),
        .read_data           (read_data),
        .instruction_address (instruction_address),
        .data_address        (data_address),
        .write_data          (write_data),
        .ctrl                (ctrl_bus.dp)
    );

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/10ps

module control_unit import rv_pkg::*; (
    ctrl_if.ctrl ctrl,
    output logic data_write,
    output logic halted
);

    opcode_e opcode;
    alu_op_e reg_alu_op;
    logic    branch_taken;

    assign opcode = opcode_e'(ctrl.opcode);

    // Register-register operation from func3 and bit 30
    always_comb begin
        case (ctrl.func3)
            funct3_add: reg_alu_op = ctrl.func7_5 ? alu_sub : alu_add;
            funct3_xor: reg_alu_op = alu_xor;
            funct3_or:  reg_alu_op = alu_or;
            funct3_and: reg_alu_op = alu_and;
            default:    reg_alu_op = alu_add;
        endcase
    end

    // Branch condition on the flags of rs1 - rs2
    always_comb begin
        case (ctrl.func3)
            funct3_beq: branch_taken = ctrl.zero;
            funct3_bne: branch_taken = !ctrl.zero;
            funct3_blt: branch_taken = ctrl.negative ^ ctrl.overflow;
            default:    branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.alua_src  = 1'b0;
        ctrl.alub_src  = 1'b0;
        ctrl.aluy_src  = 1'b0;
        ctrl.alu_op    = alu_add;
        ctrl.jump_reg  = 1'b0;
        ctrl.pc_src    = 1'b0;
        ctrl.pc_enable = 1'b1;
        ctrl.wb_sel    = wb_alu;
        ctrl.reg_write = 1'b0;
        data_write     = 1'b0;
        halted         = 1'b0;
        case (opcode)
            op_load: begin
                ctrl.alub_src  = 1'b1;
                ctrl.wb_sel    = wb_mem;
                ctrl.reg_write = 1'b1;
            end
            op_store: begin
                ctrl.alub_src = 1'b1;
                data_write    = 1'b1;
            end
            op_imm: begin
                ctrl.alub_src  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_imm32: begin
                ctrl.alub_src  = 1'b1;
                ctrl.aluy_src  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op    = reg_alu_op;
                ctrl.reg_write = 1'b1;
            end
            op_branch: begin
                ctrl.alu_op = alu_sub;
                ctrl.pc_src = branch_taken;
            end
            // ALU result is unused for jumps, link comes from PC+4
            op_jal: begin
                ctrl.alua_src  = 1'b1;
                ctrl.alub_src  = 1'b1;
                ctrl.pc_src    = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.reg_write = 1'b1;
            end
            op_jalr: begin
                ctrl.alub_src  = 1'b1;
                ctrl.jump_reg  = 1'b1;
                ctrl.pc_src    = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                ctrl.reg_write = 1'b1;
            end
            // Unknown opcode freezes the PC
            default: begin
                ctrl.pc_enable = 1'b0;
                halted         = 1'b1;
            end
        endcase
    end

endmodule

// ==== verilog/dataflow.sv ====
`timescale 1ns/10ps

module dataflow import rv_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [ilen-1:0] instruction,
    input  logic [xlen-1:0] read_data,
    output logic [xlen-1:0] instruction_address,
    output logic [xlen-1:0] data_address,
    output logic [xlen-1:0] write_data,
    ctrl_if.dp              ctrl
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] pc_plus_4;
    logic [xlen-1:0] target_base;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;

    register_file u_register_file (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (ctrl.reg_write),
        .read_address1 (instruction[19:15]),
        .read_address2 (instruction[24:20]),
        .write_address (instruction[11:7]),
        .write_data    (wb_data),
        .read_data1    (rs1_data),
        .read_data2    (rs2_data)
    );

    immediate_gen u_immediate_gen (
        .instruction (instruction),
        .immediate   (immediate)
    );

    // Operand selects
    assign alu_a = ctrl.alua_src ? pc : rs1_data;
    assign alu_b = ctrl.alub_src ? immediate : rs2_data;

    alu u_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (ctrl.alu_op),
        .y         (alu_y),
        .zero      (ctrl.zero),
        .negative  (ctrl.negative),
        .carry_out (),
        .overflow  (ctrl.overflow)
    );

    // Word result for addiw
    assign alu_result = ctrl.aluy_src ? {{(xlen-word_w){alu_y[word_w-1]}}, alu_y[word_w-1:0]}
                                      : alu_y;

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = read_data;
            wb_pc4:  wb_data = pc_plus_4;
            default: wb_data = alu_result;
        endcase
    end

    // Next PC, jalr target has bit 0 cleared
    assign pc_plus_4   = pc + inst_step;
    assign target_base = ctrl.jump_reg ? rs1_data : pc;
    assign target_sum  = target_base + immediate;
    assign pc_next     = ctrl.pc_src ? {target_sum[xlen-1:1], 1'b0} : pc_plus_4;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_enable) begin
            pc <= pc_next;
        end
    end

    assign instruction_address = pc;
    assign data_address        = alu_y;
    assign write_data          = rs2_data;

    // Fields the decoder needs
    assign ctrl.opcode  = instruction[opcode_w-1:0];
    assign ctrl.func3   = instruction[14:12];
    assign ctrl.func7_5 = instruction[30];

endmodule

// ==== verilog/immediate_gen.sv ====
`timescale 1ns/10ps

module immediate_gen import rv_pkg::*; (
    input  logic [ilen-1:0] instruction,
    output logic [xlen-1:0] immediate
);

    opcode_e opcode;

    assign opcode = opcode_e'(instruction[opcode_w-1:0]);

    // Layout picked by the major opcode, always sign-extended from bit 31
    always_comb begin
        case (opcode)
            op_load, op_imm, op_imm32, op_jalr: begin
                immediate = {{(xlen-12){instruction[31]}}, instruction[31:20]};
            end
            op_store: begin
                immediate = {{(xlen-12){instruction[31]}}, instruction[31:25],
                             instruction[11:7]};
            end
            // B and J carry an implicit zero at bit 0
            op_branch: begin
                immediate = {{(xlen-13){instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            op_jal: begin
                immediate = {{(xlen-21){instruction[31]}}, instruction[31],
                             instruction[19:12], instruction[20], instruction[30:21], 1'b0};
            end
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] y,
    output logic            zero,
    output logic            negative,
    output logic            carry_out,
    output logic            overflow
);

    logic            arithmetic;
    logic            carry_in;
    logic [xlen-1:0] b_operand;
    logic [xlen-1:0] sum;

    // Subtract is add of the inverted operand plus one
    assign carry_in   = (op == alu_sub);
    assign arithmetic = (op == alu_add) || (op == alu_sub);
    assign b_operand  = carry_in ? ~b : b;

    assign {carry_out, sum} = {1'b0, a} + {1'b0, b_operand} + {{xlen{1'b0}}, carry_in};

    // Signed overflow when both inputs agree in sign and the sum does not
    assign overflow = arithmetic && (a[xlen-1] == b_operand[xlen-1])
                      && (sum[xlen-1] != a[xlen-1]);

    always_comb begin
        case (op)
            alu_add, alu_sub: y = sum;
            alu_and:          y = a & b;
            alu_or:           y = a | b;
            alu_xor:          y = a ^ b;
            default:          y = sum;
        endcase
    end

    assign zero     = (y == '0);
    assign negative = y[xlen-1];

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/10ps

module register_file import rv_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  write_enable,
    input  logic [reg_addr_w-1:0] read_address1,
    input  logic [reg_addr_w-1:0] read_address2,
    input  logic [reg_addr_w-1:0] write_address,
    input  logic [xlen-1:0]       write_data,
    output logic [xlen-1:0]       read_data1,
    output logic [xlen-1:0]       read_data2
);

    logic [xlen-1:0] regs [reg_count];

    // Writes to x0 are dropped
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_data;
        end
    end

    // Asynchronous reads, x0 always zero
    assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
    assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

// ==== verilog/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if import rv_pkg::*; ();

    // Selects from the decoder
    logic    alua_src;
    logic    alub_src;
    logic    aluy_src;
    alu_op_e alu_op;
    logic    jump_reg;
    logic    pc_src;
    logic    pc_enable;
    wb_sel_e wb_sel;
    logic    reg_write;

    // Instruction fields and ALU flags back to the decoder
    logic [opcode_w-1:0] opcode;
    logic [funct3_w-1:0] func3;
    logic                func7_5;
    logic                zero;
    logic                negative;
    logic                overflow;

    modport ctrl (
        output alua_src, alub_src, aluy_src, alu_op, jump_reg,
        output pc_src, pc_enable, wb_sel, reg_write,
        input  opcode, func3, func7_5, zero, negative, overflow
    );

    modport dp (
        input  alua_src, alub_src, aluy_src, alu_op, jump_reg,
        input  pc_src, pc_enable, wb_sel, reg_write,
        output opcode, func3, func7_5, zero, negative, overflow
    );

endinterface

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // Datapath widths
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;

    // Major opcodes of the supported subset
    typedef enum logic [opcode_w-1:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_imm32  = 7'b0011011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // ALU operations
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_e;

    // Register writeback source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2
    } wb_sel_e;

    // Branch conditions
    localparam logic [funct3_w-1:0] funct3_beq = 3'b000;
    localparam logic [funct3_w-1:0] funct3_bne = 3'b001;
    localparam logic [funct3_w-1:0] funct3_blt = 3'b100;

    // Register-register operations
    localparam logic [funct3_w-1:0] funct3_add = 3'b000;
    localparam logic [funct3_w-1:0] funct3_xor = 3'b100;
    localparam logic [funct3_w-1:0] funct3_or  = 3'b110;
    localparam logic [funct3_w-1:0] funct3_and = 3'b111;

    // Offset between consecutive instructions
    localparam logic [xlen-1:0] inst_step = 64'd4;

endpackage
